/* Makefile */
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module clic_tb

obj_dir/Vclic_tb: vlog.f rtl/*.sv verif/*.sv
	verilator --binary --timing -f vlog.f --top-module clic_tb -Mdir obj_dir

sim: obj_dir/Vclic_tb
	./obj_dir/Vclic_tb | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

/* rtl/clic_cfg_pkg.sv */
// fixed widths and CSR map; vectors hold word addresses, so handler targets are 4-byte aligned
package clic_cfg_pkg;

  typedef logic [31:0] word_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] imem_addr_t;
  typedef logic [4:0]  zimm_t;

  // vector table stores the word address of a handler
  typedef logic [29:0] vec_addr_t;

  // id and priority as reported to the core, wide enough for 32 vectors
  typedef logic [7:0] resp_id_t;
  typedef logic [7:0] resp_prio_t;

  localparam csr_addr_t MStatusAddr    = 12'h300;
  localparam csr_addr_t MIntThreshAddr = 12'h347;
  localparam csr_addr_t StackDepthAddr = 12'h350;
  localparam csr_addr_t TimerAddr      = 12'h400;
  // vector k at VecCsrBase + k, entry k at EntryCsrBase + k
  localparam csr_addr_t VecCsrBase     = 12'hb00;
  localparam csr_addr_t EntryCsrBase   = 12'hb20;

  localparam imem_addr_t ReturnPc = '1;
  localparam int         MieBit   = 3;

  // entry layout, priority sits above enable
  localparam int PendBit = 0;
  localparam int EnBit   = 1;
  localparam int PrioLsb = 2;

endpackage

/* rtl/clic_csr_file.sv */
// CSR registers; the last entry follows irq_i and cannot be written while status holds only MIE
module clic_csr_file #(
  parameter int VecSize   = 8,
  parameter int PrioWidth = 3
) (
  input  logic                                  clk,
  input  logic                                  rst_n_i,
  input  clic_csr_pkg::csr_req_t                csr_req_i,
  input  logic                                  timer_pend_i,
  input  logic                                  pend_clr_i,
  input  logic [$clog2(VecSize)-1:0]            pend_clr_idx_i,
  input  logic                                  thresh_we_i,
  input  logic [PrioWidth-1:0]                  thresh_d_i,
  input  logic [PrioWidth:0]                    level_i,
  input  clic_cfg_pkg::word_t                   timer_rd_i,
  input  logic                                  irq_i,
  output logic [VecSize-1:0][PrioWidth+1:0]     entries_o,
  output clic_cfg_pkg::vec_addr_t [VecSize-1:0] vectors_o,
  output logic [PrioWidth-1:0]                  thresh_o,
  output logic                                  mie_o,
  output clic_cfg_pkg::word_t                   csr_data_o
);

  localparam int EntryWidth = PrioWidth + 2;

  typedef logic [EntryWidth-1:0] entry_t;

  logic                                  mie_q;
  logic                                  mie_nxt;
  logic [PrioWidth-1:0]                  thresh_q;
  logic [PrioWidth-1:0]                  thresh_nxt;
  clic_cfg_pkg::vec_addr_t [VecSize-1:0] vec_q;
  clic_cfg_pkg::vec_addr_t [VecSize-1:0] vec_nxt;
  entry_t [VecSize-2:0]                  entry_q;
  entry_t [VecSize-2:0]                  entry_nxt;
  entry_t                                ext_entry;
  clic_cfg_pkg::word_t                   status_rd;
  clic_cfg_pkg::word_t                   status_wr;

  // external line has top priority and is always enabled
  assign ext_entry = {{PrioWidth{1'b1}}, 1'b1, irq_i};

  always_comb begin
    status_rd = '0;
    status_rd[clic_cfg_pkg::MieBit] = mie_q;
    status_wr = clic_csr_pkg::csr_rmw(csr_req_i, status_rd);
    mie_nxt = mie_q;
    if (clic_csr_pkg::csr_wr(csr_req_i, clic_cfg_pkg::MStatusAddr)) begin
      mie_nxt = status_wr[clic_cfg_pkg::MieBit];
    end
  end

  // hardware threshold update wins over the core
  always_comb begin
    thresh_nxt = thresh_q;
    if (clic_csr_pkg::csr_wr(csr_req_i, clic_cfg_pkg::MIntThreshAddr)) begin
      thresh_nxt = PrioWidth'(clic_csr_pkg::csr_rmw(csr_req_i, clic_cfg_pkg::word_t'(thresh_q)));
    end
    if (thresh_we_i) begin
      thresh_nxt = thresh_d_i;
    end
  end

  always_comb begin
    vec_nxt = vec_q;
    for (int k = 0; k < VecSize; k++) begin
      if (clic_csr_pkg::csr_wr(csr_req_i,
                               clic_cfg_pkg::VecCsrBase + clic_cfg_pkg::csr_addr_t'(k))) begin
        vec_nxt[k] = clic_cfg_pkg::vec_addr_t'(
            clic_csr_pkg::csr_rmw(csr_req_i, clic_cfg_pkg::word_t'(vec_q[k])));
      end
    end
  end

  // pend clear from a take before the timer set so a fresh event is not lost
  always_comb begin
    entry_nxt = entry_q;
    for (int k = 0; k < VecSize - 1; k++) begin
      if (clic_csr_pkg::csr_wr(csr_req_i,
                               clic_cfg_pkg::EntryCsrBase + clic_cfg_pkg::csr_addr_t'(k))) begin
        entry_nxt[k] = entry_t'(
            clic_csr_pkg::csr_rmw(csr_req_i, clic_cfg_pkg::word_t'(entry_q[k])));
      end
      if (pend_clr_i && (int'(pend_clr_idx_i) == k)) begin
        entry_nxt[k][clic_cfg_pkg::PendBit] = 1'b0;
      end
    end
    if (timer_pend_i) begin
      entry_nxt[0][clic_cfg_pkg::PendBit] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mie_q    <= 1'b0;
      thresh_q <= '0;
      vec_q    <= '0;
      entry_q  <= '0;
    end else begin
      mie_q    <= mie_nxt;
      thresh_q <= thresh_nxt;
      vec_q    <= vec_nxt;
      entry_q  <= entry_nxt;
    end
  end

  assign entries_o = {ext_entry, entry_q};
  assign vectors_o = vec_q;
  assign thresh_o  = thresh_q;
  assign mie_o     = mie_q;

  // read mux with unknown addresses reading zero
  always_comb begin
    csr_data_o = '0;
    if (csr_req_i.addr == clic_cfg_pkg::MStatusAddr) begin
      csr_data_o = status_rd;
    end else if (csr_req_i.addr == clic_cfg_pkg::MIntThreshAddr) begin
      csr_data_o = clic_cfg_pkg::word_t'(thresh_q);
    end else if (csr_req_i.addr == clic_cfg_pkg::TimerAddr) begin
      csr_data_o = timer_rd_i;
    end else if (csr_req_i.addr == clic_cfg_pkg::StackDepthAddr) begin
      csr_data_o = clic_cfg_pkg::word_t'(level_i);
    end else begin
      for (int k = 0; k < VecSize; k++) begin
        if (csr_req_i.addr == clic_cfg_pkg::VecCsrBase + clic_cfg_pkg::csr_addr_t'(k)) begin
          csr_data_o = clic_cfg_pkg::word_t'(vec_q[k]);
        end
        if (csr_req_i.addr == clic_cfg_pkg::EntryCsrBase + clic_cfg_pkg::csr_addr_t'(k)) begin
          csr_data_o = clic_cfg_pkg::word_t'(entries_o[k]);
        end
      end
    end
  end

endmodule

/* rtl/clic_csr_pkg.sv */
// CSR request and response types; stacked priority is 8 bits, so PrioWidth must not exceed 8
package clic_csr_pkg;

  typedef enum logic [2:0] {
    CSR_NONE,
    CSR_RW,
    CSR_RS,
    CSR_RC,
    CSR_RWI,
    CSR_RSI,
    CSR_RCI
  } csr_op_t;

  typedef enum logic {
    PC_NORMAL,
    PC_INTERRUPT
  } pc_sel_t;

  // request from the core, acts at the next edge
  typedef struct packed {
    logic                    enable;
    clic_cfg_pkg::csr_addr_t addr;
    csr_op_t                 op;
    clic_cfg_pkg::zimm_t     zimm;
    clic_cfg_pkg::word_t     data;
  } csr_req_t;

  // decision handed to the core in the same cycle
  typedef struct packed {
    logic                     irq;
    logic                     tail_chain;
    pc_sel_t                  pc_sel;
    clic_cfg_pkg::imem_addr_t addr;
    clic_cfg_pkg::resp_id_t   id;
    clic_cfg_pkg::resp_prio_t prio;
  } irq_resp_t;

  // interrupted pc with the threshold to restore on return
  typedef struct packed {
    clic_cfg_pkg::imem_addr_t pc;
    clic_cfg_pkg::resp_prio_t prio;
  } stack_entry_t;

  function automatic logic csr_wr(csr_req_t req, clic_cfg_pkg::csr_addr_t addr);
    return req.enable && (req.op != CSR_NONE) && (req.addr == addr);
  endfunction

  // read-modify-write rule shared by every CSR
  function automatic clic_cfg_pkg::word_t csr_rmw(csr_req_t req, clic_cfg_pkg::word_t old);
    clic_cfg_pkg::word_t src;
    src = (req.op inside {CSR_RWI, CSR_RSI, CSR_RCI}) ?
          clic_cfg_pkg::word_t'(req.zimm) : req.data;
    case (req.op)
      CSR_RW, CSR_RWI: return src;
      CSR_RS, CSR_RSI: return old | src;
      CSR_RC, CSR_RCI: return old & ~src;
      default:         return old;
    endcase
  endfunction

endpackage

/* rtl/clic_ctrl.sv */
// combinational decision; the core must follow it in the same cycle, there is no handshake
module clic_ctrl #(
  parameter int VecSize   = 8,
  parameter int PrioWidth = 3
) (
  input  clic_cfg_pkg::imem_addr_t   pc_i,
  input  logic                       irq_i,
  input  logic                       mie_i,
  input  logic [PrioWidth-1:0]       thresh_i,
  input  logic                       sel_valid_i,
  input  logic [$clog2(VecSize)-1:0] sel_idx_i,
  input  logic [PrioWidth-1:0]       sel_prio_i,
  input  clic_cfg_pkg::vec_addr_t    sel_vec_i,
  input  clic_csr_pkg::stack_entry_t stack_top_i,
  output logic                       push_o,
  output logic                       pop_o,
  output logic                       thresh_we_o,
  output logic [PrioWidth-1:0]       thresh_d_o,
  output logic                       pend_clr_o,
  output logic [$clog2(VecSize)-1:0] pend_clr_idx_o,
  output clic_csr_pkg::irq_resp_t    resp_o
);

  logic at_return;
  logic take;

  assign at_return      = (pc_i == clic_cfg_pkg::ReturnPc);
  assign pend_clr_idx_o = sel_idx_i;

  always_comb begin
    take        = 1'b0;
    push_o      = 1'b0;
    pop_o       = 1'b0;
    thresh_we_o = 1'b0;
    thresh_d_o  = '0;
    resp_o      = '{irq:        1'b0,
                    tail_chain: 1'b0,
                    pc_sel:     clic_csr_pkg::PC_NORMAL,
                    addr:       pc_i,
                    id:         '0,
                    prio:       clic_cfg_pkg::resp_prio_t'(thresh_i)};

    if (!mie_i && !irq_i) begin
      // globally masked, keep running
      take = 1'b0;
    end else if ((sel_prio_i > thresh_i) || irq_i) begin
      take   = 1'b1;
      push_o = 1'b1;
    end else if (at_return && sel_valid_i) begin
      // tail chain, the stacked context stays
      take              = 1'b1;
      resp_o.tail_chain = 1'b1;
    end else if (at_return) begin
      pop_o         = 1'b1;
      thresh_we_o   = 1'b1;
      thresh_d_o    = PrioWidth'(stack_top_i.prio);
      resp_o.pc_sel = clic_csr_pkg::PC_INTERRUPT;
      resp_o.addr   = stack_top_i.pc;
      resp_o.prio   = stack_top_i.prio;
    end

    if (take) begin
      thresh_we_o   = 1'b1;
      thresh_d_o    = sel_prio_i;
      resp_o.irq    = 1'b1;
      resp_o.pc_sel = clic_csr_pkg::PC_INTERRUPT;
      // word address to byte address
      resp_o.addr   = {sel_vec_i, 2'b00};
      resp_o.id     = clic_cfg_pkg::resp_id_t'(sel_idx_i);
      resp_o.prio   = clic_cfg_pkg::resp_prio_t'(sel_prio_i);
    end
  end

  assign pend_clr_o = take;

endmodule

/* rtl/clic_epc_stack.sv */
// pc and threshold stack of depth 2**PrioWidth; push when full and pop when empty are dropped
module clic_epc_stack #(
  parameter int PrioWidth = 3
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       push_i,
  input  logic                       pop_i,
  input  clic_csr_pkg::stack_entry_t data_i,
  output clic_csr_pkg::stack_entry_t top_o,
  output logic [PrioWidth:0]         level_o
);

  localparam int Depth = 2 ** PrioWidth;

  clic_csr_pkg::stack_entry_t mem_q [Depth];
  logic [PrioWidth:0]         level_q;
  logic [PrioWidth-1:0]       top_idx;
  logic                       full;
  logic                       empty;

  assign full    = (level_q == (PrioWidth + 1)'(Depth));
  assign empty   = (level_q == '0);
  assign top_idx = PrioWidth'(level_q - 1'b1);

  always_ff @(posedge clk) begin
    if (push_i && !full) begin
      mem_q[level_q[PrioWidth-1:0]] <= data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      level_q <= '0;
    end else if (push_i && !full) begin
      level_q <= level_q + 1'b1;
    end else if (pop_i && !empty) begin
      level_q <= level_q - 1'b1;
    end
  end

  assign top_o   = mem_q[top_idx];
  assign level_o = level_q;

endmodule

/* rtl/clic_prio_select.sv */
// finds the winning vector; with nothing valid the priority output equals the threshold
module clic_prio_select #(
  parameter int VecSize   = 8,
  parameter int PrioWidth = 3
) (
  input  logic [VecSize-1:0][PrioWidth+1:0]     entries_i,
  input  clic_cfg_pkg::vec_addr_t [VecSize-1:0] vectors_i,
  input  logic [PrioWidth-1:0]                  thresh_i,
  input  logic                                  irq_i,
  output logic                                  valid_o,
  output logic [$clog2(VecSize)-1:0]            idx_o,
  output logic [PrioWidth-1:0]                  prio_o,
  output clic_cfg_pkg::vec_addr_t               vec_o
);

  localparam int IdxWidth = $clog2(VecSize);
  localparam int Last     = VecSize - 1;

  logic [PrioWidth-1:0] prio_k;
  logic                 en_k;
  logic                 pend_k;

  // chain from index 0 upward, >= lets the higher index win a tie
  always_comb begin
    valid_o = 1'b0;
    idx_o   = '0;
    prio_o  = thresh_i;
    vec_o   = '0;
    prio_k  = '0;
    en_k    = 1'b0;
    pend_k  = 1'b0;
    for (int k = 0; k < VecSize; k++) begin
      if (k == Last) begin
        // external line
        prio_k = '1;
        en_k   = 1'b1;
        pend_k = irq_i;
      end else begin
        prio_k = entries_i[k][clic_cfg_pkg::PrioLsb +: PrioWidth];
        en_k   = entries_i[k][clic_cfg_pkg::EnBit];
        pend_k = entries_i[k][clic_cfg_pkg::PendBit];
      end
      if (en_k && pend_k && (prio_k >= prio_o)) begin
        valid_o = 1'b1;
        idx_o   = IdxWidth'(k);
        prio_o  = prio_k;
        vec_o   = vectors_i[k];
      end
    end
  end

endmodule

/* rtl/clic_timer.sv */
// compare timer; a zero compare disables the pend, and writing the compare restarts the count
module clic_timer (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  clic_csr_pkg::csr_req_t csr_req_i,
  output logic                   pend_o,
  output clic_cfg_pkg::word_t    timer_rd_o
);

  clic_cfg_pkg::word_t cnt_q;
  clic_cfg_pkg::word_t cmp_q;
  logic                cmp_we;

  assign cmp_we = clic_csr_pkg::csr_wr(csr_req_i, clic_cfg_pkg::TimerAddr);

  // one cycle pulse, the counter restarts on the next edge
  assign pend_o = (cmp_q != '0) && (cnt_q == cmp_q);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      cmp_q <= '0;
    end else begin
      if (cmp_we) begin
        cmp_q <= clic_csr_pkg::csr_rmw(csr_req_i, cmp_q);
        cnt_q <= '0;
      end else if (pend_o) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign timer_rd_o = cmp_q;

endmodule

/* rtl/clic_top.sv */
// interrupt controller top; VecSize up to 32 with the last vector on irq_i, PrioWidth up to 8
module clic_top #(
  parameter int VecSize   = 8,
  parameter int PrioWidth = 3
) (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  clic_csr_pkg::csr_req_t   csr_req_i,
  input  clic_cfg_pkg::imem_addr_t pc_i,
  input  logic                     irq_i,
  output clic_cfg_pkg::word_t      csr_data_o,
  output clic_csr_pkg::irq_resp_t  resp_o,
  output logic [PrioWidth:0]       level_o
);

  localparam int IdxWidth = $clog2(VecSize);

  logic                                  timer_pend;
  clic_cfg_pkg::word_t                   timer_rd;
  logic [VecSize-1:0][PrioWidth+1:0]     entries;
  clic_cfg_pkg::vec_addr_t [VecSize-1:0] vectors;
  logic [PrioWidth-1:0]                  thresh;
  logic                                  mie;
  logic                                  sel_valid;
  logic [IdxWidth-1:0]                   sel_idx;
  logic [PrioWidth-1:0]                  sel_prio;
  clic_cfg_pkg::vec_addr_t               sel_vec;
  logic                                  push;
  logic                                  pop;
  clic_csr_pkg::stack_entry_t            push_data;
  clic_csr_pkg::stack_entry_t            stack_top;
  logic                                  thresh_we;
  logic [PrioWidth-1:0]                  thresh_d;
  logic                                  pend_clr;
  logic [IdxWidth-1:0]                   pend_clr_idx;

  // interrupted pc with the threshold it ran at
  assign push_data = '{pc: pc_i, prio: clic_cfg_pkg::resp_prio_t'(thresh)};

  clic_timer u_timer (
    .clk,
    .rst_n_i,
    .csr_req_i,
    .pend_o     (timer_pend),
    .timer_rd_o (timer_rd)
  );

  clic_csr_file #(.VecSize(VecSize), .PrioWidth(PrioWidth)) u_csr_file (
    .clk,
    .rst_n_i,
    .csr_req_i,
    .timer_pend_i   (timer_pend),
    .pend_clr_i     (pend_clr),
    .pend_clr_idx_i (pend_clr_idx),
    .thresh_we_i    (thresh_we),
    .thresh_d_i     (thresh_d),
    .level_i        (level_o),
    .timer_rd_i     (timer_rd),
    .irq_i,
    .entries_o      (entries),
    .vectors_o      (vectors),
    .thresh_o       (thresh),
    .mie_o          (mie),
    .csr_data_o
  );

  clic_prio_select #(.VecSize(VecSize), .PrioWidth(PrioWidth)) u_prio_select (
    .entries_i (entries),
    .vectors_i (vectors),
    .thresh_i  (thresh),
    .irq_i,
    .valid_o   (sel_valid),
    .idx_o     (sel_idx),
    .prio_o    (sel_prio),
    .vec_o     (sel_vec)
  );

  clic_epc_stack #(.PrioWidth(PrioWidth)) u_epc_stack (
    .clk,
    .rst_n_i,
    .push_i  (push),
    .pop_i   (pop),
    .data_i  (push_data),
    .top_o   (stack_top),
    .level_o
  );

  clic_ctrl #(.VecSize(VecSize), .PrioWidth(PrioWidth)) u_ctrl (
    .pc_i,
    .irq_i,
    .mie_i          (mie),
    .thresh_i       (thresh),
    .sel_valid_i    (sel_valid),
    .sel_idx_i      (sel_idx),
    .sel_prio_i     (sel_prio),
    .sel_vec_i      (sel_vec),
    .stack_top_i    (stack_top),
    .push_o         (push),
    .pop_o          (pop),
    .thresh_we_o    (thresh_we),
    .thresh_d_o     (thresh_d),
    .pend_clr_o     (pend_clr),
    .pend_clr_idx_o (pend_clr_idx),
    .resp_o
  );

endmodule

/* verif/clic_tb.sv */
// testbench for clic_top with VecSize 8 and PrioWidth 3; rows are built from a register model
module clic_tb;

  localparam int VecSize   = 8;
  localparam int PrioWidth = 3;
  localparam int MaxRows   = 96;
  localparam int Period    = 40;
  localparam int PollLimit = 9;
  localparam clic_cfg_pkg::imem_addr_t NormalPc = 32'h0000_0800;

  logic                       clk;
  logic                       rst_n;
  clic_csr_pkg::csr_req_t     csr_req;
  clic_cfg_pkg::imem_addr_t   pc;
  logic                       irq;
  clic_cfg_pkg::word_t        csr_data;
  clic_csr_pkg::irq_resp_t    resp;
  logic [PrioWidth:0]         level;

  // stimulus and expected values per row
  string                      row_name [MaxRows];
  clic_csr_pkg::csr_req_t     row_req [MaxRows];
  clic_cfg_pkg::imem_addr_t   row_pc [MaxRows];
  logic                       row_irq [MaxRows];
  logic                       row_poll [MaxRows];
  clic_cfg_pkg::word_t        row_data [MaxRows];
  clic_csr_pkg::irq_resp_t    row_resp [MaxRows];
  logic [PrioWidth:0]         row_level [MaxRows];
  int                         n_rows = 0;

  // register model used while the table is built
  clic_cfg_pkg::word_t        model [4096];
  logic [PrioWidth:0]         m_level = '0;
  clic_cfg_pkg::imem_addr_t   stk_pc [$];
  clic_cfg_pkg::word_t        stk_prio [$];
  logic [31:0]                lcg_state;

  int errors = 0;
  int cycles = 0;
  int limit  = 1000;
  logic row_bad;

  clic_top #(.VecSize(VecSize), .PrioWidth(PrioWidth)) DUT (
    .clk        (clk),
    .rst_n_i    (rst_n),
    .csr_req_i  (csr_req),
    .pc_i       (pc),
    .irq_i      (irq),
    .csr_data_o (csr_data),
    .resp_o     (resp),
    .level_o    (level)
  );

  initial begin
    clk = 1'b0;
    forever #(Period / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("run stopped, no progress after %0d cycles", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic clic_cfg_pkg::word_t apply_op(clic_csr_pkg::csr_op_t op,
                                                   clic_cfg_pkg::zimm_t zimm,
                                                   clic_cfg_pkg::word_t data,
                                                   clic_cfg_pkg::word_t old);
    clic_cfg_pkg::word_t src;
    src = data;
    if (op == clic_csr_pkg::CSR_RWI || op == clic_csr_pkg::CSR_RSI ||
        op == clic_csr_pkg::CSR_RCI) begin
      src = {27'b0, zimm};
    end
    case (op)
      clic_csr_pkg::CSR_RW, clic_csr_pkg::CSR_RWI: return src;
      clic_csr_pkg::CSR_RS, clic_csr_pkg::CSR_RSI: return old | src;
      clic_csr_pkg::CSR_RC, clic_csr_pkg::CSR_RCI: return old & ~src;
      default: return old;
    endcase
  endfunction

  // writable bits per address
  function automatic clic_cfg_pkg::word_t write_mask(clic_cfg_pkg::csr_addr_t a);
    if (a == clic_cfg_pkg::MStatusAddr) return 32'h8;
    if (a == clic_cfg_pkg::MIntThreshAddr) return 32'h7;
    if (a == clic_cfg_pkg::TimerAddr) return '1;
    if (a >= clic_cfg_pkg::VecCsrBase && a < clic_cfg_pkg::VecCsrBase + VecSize) begin
      return 32'h3fff_ffff;
    end
    if (a >= clic_cfg_pkg::EntryCsrBase && a < clic_cfg_pkg::EntryCsrBase + VecSize - 1) begin
      return 32'h1f;
    end
    return '0;
  endfunction

  function automatic clic_cfg_pkg::word_t model_read(clic_cfg_pkg::csr_addr_t a, logic line);
    // external entry has priority 7 and is pended by the line
    if (a == clic_cfg_pkg::EntryCsrBase + VecSize - 1) return 32'h1e | {31'b0, line};
    if (a == clic_cfg_pkg::StackDepthAddr) return {28'b0, m_level};
    return model[a];
  endfunction

  function automatic clic_csr_pkg::csr_req_t new_req(logic en, clic_cfg_pkg::csr_addr_t a,
                                                     clic_csr_pkg::csr_op_t op,
                                                     clic_cfg_pkg::zimm_t zimm,
                                                     clic_cfg_pkg::word_t data);
    clic_csr_pkg::csr_req_t r;
    r.enable = en;
    r.addr   = a;
    r.op     = op;
    r.zimm   = zimm;
    r.data   = data;
    return r;
  endfunction

  function automatic clic_csr_pkg::irq_resp_t resp_value(logic flag, logic tail,
                                                         clic_csr_pkg::pc_sel_t sel,
                                                         clic_cfg_pkg::imem_addr_t target,
                                                         int id, clic_cfg_pkg::word_t prio);
    clic_csr_pkg::irq_resp_t r;
    r.irq        = flag;
    r.tail_chain = tail;
    r.pc_sel     = sel;
    r.addr       = target;
    r.id         = 8'(id);
    r.prio       = 8'(prio);
    return r;
  endfunction

  function automatic clic_csr_pkg::irq_resp_t idle_resp(clic_cfg_pkg::imem_addr_t p);
    return resp_value(1'b0, 1'b0, clic_csr_pkg::PC_NORMAL, p, 0,
                      model[clic_cfg_pkg::MIntThreshAddr]);
  endfunction

  task automatic append_row(string name, clic_csr_pkg::csr_req_t req,
                            clic_cfg_pkg::imem_addr_t p, logic line, logic poll,
                            clic_cfg_pkg::word_t data, clic_csr_pkg::irq_resp_t r);
    row_name[n_rows]  = name;
    row_req[n_rows]   = req;
    row_pc[n_rows]    = p;
    row_irq[n_rows]   = line;
    row_poll[n_rows]  = poll;
    row_data[n_rows]  = data;
    row_resp[n_rows]  = r;
    row_level[n_rows] = m_level;
    n_rows++;
  endtask

  // core CSR access at a normal pc where the read shows the old value
  task automatic csr_row(string name, clic_cfg_pkg::csr_addr_t a,
                         clic_csr_pkg::csr_op_t op, clic_cfg_pkg::zimm_t zimm,
                         clic_cfg_pkg::word_t data);
    append_row(name, new_req(1'b1, a, op, zimm, data), NormalPc, 1'b0, 1'b0,
               model_read(a, 1'b0), idle_resp(NormalPc));
    if (op != clic_csr_pkg::CSR_NONE) begin
      model[a] = apply_op(op, zimm, data, model[a]) & write_mask(a);
    end
  endtask

  task automatic idle_row(string name, clic_cfg_pkg::imem_addr_t p,
                          clic_cfg_pkg::csr_addr_t a);
    append_row(name, new_req(1'b0, a, clic_csr_pkg::CSR_NONE, '0, '0), p, 1'b0, 1'b0,
               model_read(a, 1'b0), idle_resp(p));
  endtask

  task automatic take_row(string name, clic_cfg_pkg::imem_addr_t p, logic line, int idx,
                          logic tail, clic_cfg_pkg::csr_addr_t a);
    clic_cfg_pkg::word_t prio;
    clic_cfg_pkg::imem_addr_t target;
    prio = (idx == VecSize - 1) ? 32'd7 : {29'b0, model[clic_cfg_pkg::EntryCsrBase + idx][4:2]};
    target = {model[clic_cfg_pkg::VecCsrBase + idx][29:0], 2'b00};
    append_row(name, new_req(1'b0, a, clic_csr_pkg::CSR_NONE, '0, '0), p, line, 1'b0,
               model_read(a, line),
               resp_value(1'b1, tail, clic_csr_pkg::PC_INTERRUPT, target, idx, prio));
    if (!tail) begin
      stk_pc.push_back(p);
      stk_prio.push_back(model[clic_cfg_pkg::MIntThreshAddr]);
      m_level++;
    end
    model[clic_cfg_pkg::MIntThreshAddr] = prio;
    if (idx < VecSize - 1) begin
      model[clic_cfg_pkg::EntryCsrBase + idx][0] = 1'b0;
    end
  endtask

  task automatic return_row(string name, clic_cfg_pkg::csr_addr_t a);
    clic_cfg_pkg::imem_addr_t p;
    clic_cfg_pkg::word_t pr;
    p  = stk_pc.pop_back();
    pr = stk_prio.pop_back();
    append_row(name, new_req(1'b0, a, clic_csr_pkg::CSR_NONE, '0, '0),
               clic_cfg_pkg::ReturnPc, 1'b0, 1'b0, model_read(a, 1'b0),
               resp_value(1'b0, 1'b0, clic_csr_pkg::PC_INTERRUPT, p, 0, pr));
    model[clic_cfg_pkg::MIntThreshAddr] = pr;
    m_level--;
  endtask

  task automatic build_table();
    clic_cfg_pkg::csr_addr_t st;
    clic_cfg_pkg::csr_addr_t th;
    clic_cfg_pkg::csr_addr_t vb;
    clic_cfg_pkg::csr_addr_t eb;
    st = clic_cfg_pkg::MStatusAddr;
    th = clic_cfg_pkg::MIntThreshAddr;
    vb = clic_cfg_pkg::VecCsrBase;
    eb = clic_cfg_pkg::EntryCsrBase;
    // register and immediate ops with random data
    csr_row("status_rw", st, clic_csr_pkg::CSR_RW, '0, lcg_next());
    csr_row("status_rs", st, clic_csr_pkg::CSR_RS, '0, lcg_next());
    csr_row("status_rc", st, clic_csr_pkg::CSR_RC, '0, lcg_next());
    csr_row("status_rwi", st, clic_csr_pkg::CSR_RWI, 5'(lcg_next()), '0);
    csr_row("status_rsi", st, clic_csr_pkg::CSR_RSI, 5'(lcg_next()), '0);
    csr_row("status_rci", st, clic_csr_pkg::CSR_RCI, 5'h08, '0);
    csr_row("status_read", st, clic_csr_pkg::CSR_NONE, '0, '0);
    csr_row("thresh_rw", th, clic_csr_pkg::CSR_RW, '0, lcg_next());
    csr_row("thresh_rc", th, clic_csr_pkg::CSR_RC, '0, lcg_next());
    csr_row("thresh_rs", th, clic_csr_pkg::CSR_RS, '0, lcg_next());
    csr_row("thresh_rci", th, clic_csr_pkg::CSR_RCI, 5'(lcg_next()), '0);
    csr_row("thresh_rsi", th, clic_csr_pkg::CSR_RSI, 5'(lcg_next()), '0);
    csr_row("thresh_rwi", th, clic_csr_pkg::CSR_RWI, 5'(lcg_next()), '0);
    csr_row("thresh_read", th, clic_csr_pkg::CSR_NONE, '0, '0);
    for (int k = 0; k < VecSize; k++) begin
      csr_row($sformatf("vec%0d_rw", k), vb + 12'(k), clic_csr_pkg::CSR_RW, '0, lcg_next());
    end
    csr_row("vec3_rs", vb + 12'd3, clic_csr_pkg::CSR_RS, '0, lcg_next());
    csr_row("vec3_rci", vb + 12'd3, clic_csr_pkg::CSR_RCI, 5'(lcg_next()), '0);
    csr_row("vec3_read", vb + 12'd3, clic_csr_pkg::CSR_NONE, '0, '0);
    csr_row("entry1_rw", eb + 12'd1, clic_csr_pkg::CSR_RW, '0, lcg_next());
    csr_row("entry1_rc", eb + 12'd1, clic_csr_pkg::CSR_RC, '0, lcg_next());
    csr_row("entry1_rsi", eb + 12'd1, clic_csr_pkg::CSR_RSI, 5'(lcg_next()), '0);
    csr_row("entry3_rwi", eb + 12'd3, clic_csr_pkg::CSR_RWI, 5'(lcg_next()), '0);
    csr_row("entry3_rs", eb + 12'd3, clic_csr_pkg::CSR_RS, '0, lcg_next());
    csr_row("entry3_rci", eb + 12'd3, clic_csr_pkg::CSR_RCI, 5'(lcg_next()), '0);
    csr_row("entry1_read", eb + 12'd1, clic_csr_pkg::CSR_NONE, '0, '0);
    csr_row("entry3_read", eb + 12'd3, clic_csr_pkg::CSR_NONE, '0, '0);
    csr_row("entry7_read", eb + 12'd7, clic_csr_pkg::CSR_NONE, '0, '0);
    csr_row("unknown_rw", 12'h123, clic_csr_pkg::CSR_RW, '0, lcg_next());
    csr_row("unknown_read", 12'h123, clic_csr_pkg::CSR_NONE, '0, '0);
    // known setup with vector k at word 0x100 + 16k and all entries cleared
    csr_row("thresh_zero", th, clic_csr_pkg::CSR_RW, '0, '0);
    for (int k = 0; k < VecSize; k++) begin
      csr_row($sformatf("vec%0d_set", k), vb + 12'(k), clic_csr_pkg::CSR_RW, '0,
              32'h100 + 32'(k * 16));
    end
    for (int k = 0; k < VecSize - 1; k++) begin
      csr_row($sformatf("entry%0d_clr", k), eb + 12'(k), clic_csr_pkg::CSR_RW, '0, '0);
    end
    // entries 2 and 5 tie at priority 3 above entries 4 and 6
    csr_row("entry2_p3", eb + 12'd2, clic_csr_pkg::CSR_RW, '0, 32'h0f);
    csr_row("entry5_p3", eb + 12'd5, clic_csr_pkg::CSR_RW, '0, 32'h0f);
    csr_row("entry4_p2", eb + 12'd4, clic_csr_pkg::CSR_RW, '0, 32'h0b);
    csr_row("entry6_p2", eb + 12'd6, clic_csr_pkg::CSR_RW, '0, 32'h0b);
    idle_row("mie_off", 32'h1000, eb + 12'd2);
    csr_row("mie_on", st, clic_csr_pkg::CSR_RS, '0, 32'h8);
    take_row("take_tie", 32'h1000, 1'b0, 5, 1'b0, th);
    idle_row("after_take_entry", 32'h0500, eb + 12'd5);
    idle_row("after_take_thresh", 32'h0504, th);
    take_row("tail_chain", clic_cfg_pkg::ReturnPc, 1'b0, 2, 1'b1, eb + 12'd2);
    idle_row("after_tail", 32'h0600, eb + 12'd2);
    csr_row("entry6_p6", eb + 12'd6, clic_csr_pkg::CSR_RW, '0, 32'h1b);
    take_row("take_preempt", 32'h2000, 1'b0, 6, 1'b0, eb + 12'd6);
    idle_row("nested_thresh", 32'h0700, th);
    return_row("return_inner", th);
    idle_row("restored_thresh", 32'h2000, th);
    return_row("return_outer", eb + 12'd4);
    take_row("take_low", 32'h1000, 1'b0, 4, 1'b0, th);
    take_row("take_ext", 32'h3000, 1'b1, VecSize - 1, 1'b0, eb + 12'd7);
    idle_row("depth_read", 32'h1000, clic_cfg_pkg::StackDepthAddr);
    return_row("return_ext", th);
    return_row("return_low", th);
    // timer pends entry 0 with mie off before a take once mie is set
    csr_row("mie_clear", st, clic_csr_pkg::CSR_RCI, 5'h08, '0);
    csr_row("entry0_en", eb, clic_csr_pkg::CSR_RW, '0, 32'h06);
    csr_row("timer_cmp", clic_cfg_pkg::TimerAddr, clic_csr_pkg::CSR_RW, '0, 32'd5);
    csr_row("timer_read", clic_cfg_pkg::TimerAddr, clic_csr_pkg::CSR_NONE, '0, '0);
    append_row("timer_poll", new_req(1'b0, eb, clic_csr_pkg::CSR_NONE, '0, '0), NormalPc,
               1'b0, 1'b1, 32'h07, idle_resp(NormalPc));
    model[eb] = 32'h07;
    csr_row("mie_set", st, clic_csr_pkg::CSR_RSI, 5'h08, '0);
    take_row("take_timer", 32'h4000, 1'b0, 0, 1'b0, eb);
    idle_row("timer_thresh", NormalPc, th);
  endtask

  task automatic check(string name, string what, logic [63:0] exp, logic [63:0] act);
    if (exp !== act) begin
      $display("error %s %s expected %h actual %h", name, what, exp, act);
      errors++;
      row_bad = 1'b1;
    end
  endtask

  initial begin
    int tries;
    rst_n   = 1'b0;
    csr_req = '0;
    pc      = NormalPc;
    irq     = 1'b0;
    lcg_state = 32'hc8f4_6c28;
    foreach (model[a]) model[a] = '0;
    build_table();
    limit = n_rows * 4 + 200;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      @(negedge clk);
      csr_req = row_req[i];
      pc      = row_pc[i];
      irq     = row_irq[i];
      row_bad = 1'b0;
      #10;
      tries = 0;
      while (row_poll[i] && csr_data !== row_data[i] && tries < PollLimit) begin
        @(negedge clk);
        #10;
        tries++;
      end
      check(row_name[i], "csr_data", 64'(row_data[i]), 64'(csr_data));
      check(row_name[i], "resp", 64'(row_resp[i]), 64'(resp));
      check(row_name[i], "level", 64'(row_level[i]), 64'(level));
      $display("row %0d %s %s", i, row_name[i], row_bad ? "failed" : "ok");
    end
    @(negedge clk);
    csr_req = '0;
    $display("%0d rows run, %0d errors", n_rows, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
rtl/clic_cfg_pkg.sv
rtl/clic_csr_pkg.sv
rtl/clic_csr_file.sv
rtl/clic_timer.sv
rtl/clic_prio_select.sv
rtl/clic_epc_stack.sv
rtl/clic_ctrl.sv
rtl/clic_top.sv
verif/clic_tb.sv
